/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // word geometry
    localparam int bytes_per_word = 4;
    localparam int bits_per_word  = 32;

    typedef logic [7:0]                 byte_t;
    typedef logic [bits_per_word - 1:0] word_t;
    typedef logic [31:0]                addr_t;

    // merging works on bytes, storage and transfer on whole words
    typedef union packed {
        word_t                        word;
        byte_t [bytes_per_word - 1:0] bytes;
    } word_view_t;

    // one bit per byte lane
    typedef logic [bytes_per_word - 1:0] strobe_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // processor side
    typedef struct packed {
        logic         req;
        logic         wr;
        access_size_t size;
        addr_t        addr;
        word_view_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } mem_resp_t;

    // cache bus, burst length is always one line
    typedef struct packed {
        logic  valid;
        logic  is_write;
        addr_t addr;
        word_t wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

/* verilog/strobe_translator.sv */
`timescale 1ns/1ps
`default_nettype none

module strobe_translator
    import cache_pkg::*;
(
    input  access_size_t size,
    input  logic [1:0]   offset,
    output strobe_t      strobe
);

    always_comb begin
        unique case (size)
            size_byte: strobe = strobe_t'(4'b0001 << offset);
            // lane pair picked by the high offset bit
            size_half: strobe = offset[1] ? 4'b1100 : 4'b0011;
            size_word: strobe = 4'b1111;
            default:   strobe = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/one_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module one_line_buffer
    import cache_pkg::*;
#(
    parameter int line_words = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  mem_req_t   mem_req,
    output mem_resp_t  mem_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    localparam int align_bits = $clog2(bytes_per_word);
    localparam int index_bits = $clog2(line_words);
    localparam int tag_bits   = 32 - index_bits - align_bits;

    typedef logic [align_bits - 1:0] align_t;
    typedef logic [index_bits - 1:0] index_t;
    typedef logic [tag_bits - 1:0]   tag_t;

    typedef struct packed {
        tag_t   tag;
        index_t index;
        align_t align;
    } line_addr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_refill
    } state_t;

    // line state
    logic       valid;
    logic       dirty;
    tag_t       tag;
    word_view_t line_mem [line_words];
    state_t     state;
    index_t     beat;

    // the request that missed
    mem_req_t   saved_req;

    line_addr_t req_addr;
    line_addr_t saved_addr;
    logic       tag_hit;
    logic       offset_hit;
    strobe_t    req_strb;
    strobe_t    saved_strb;
    word_view_t fill_word;

    assign req_addr   = mem_req.addr;
    assign saved_addr = saved_req.addr;
    assign tag_hit    = valid && tag == req_addr.tag;
    assign offset_hit = beat == saved_addr.index;

    strobe_translator req_strb_i (
        .size   (mem_req.size),
        .offset (req_addr.align),
        .strobe (req_strb)
    );

    strobe_translator saved_strb_i (
        .size   (saved_req.size),
        .offset (saved_addr.align),
        .strobe (saved_strb)
    );

    // refill beat, with pending write bytes merged in
    always_comb begin
        fill_word.word = cbus_resp.rdata;
        if (offset_hit && saved_req.wr) begin
            for (int i = 0; i < bytes_per_word; i++) begin
                if (saved_strb[i])
                    fill_word.bytes[i] = saved_req.wdata.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            dirty <= 1'b0;
            beat  <= '0;
            state <= st_idle;
        end else begin
            unique case (state)
                st_idle: begin
                    if (mem_req.req && tag_hit) begin
                        if (mem_req.wr)
                            dirty <= 1'b1;
                    end else if (mem_req.req) begin
                        state <= dirty ? st_write_back : st_refill;
                    end
                end
                st_write_back: begin
                    // beat wraps to zero on the last beat
                    if (cbus_resp.okay)
                        beat <= beat + 1'b1;
                    if (cbus_resp.last)
                        state <= st_refill;
                end
                st_refill: begin
                    if (cbus_resp.okay)
                        beat <= beat + 1'b1;
                    if (cbus_resp.last) begin
                        state <= st_idle;
                        valid <= 1'b1;
                        dirty <= saved_req.wr;
                        tag   <= saved_addr.tag;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line data and saved request, no reset
    always_ff @(posedge clk) begin
        if (state == st_idle && mem_req.req) begin
            if (tag_hit && mem_req.wr) begin
                for (int i = 0; i < bytes_per_word; i++) begin
                    if (req_strb[i])
                        line_mem[req_addr.index].bytes[i] <= mem_req.wdata.bytes[i];
                end
            end else if (!tag_hit) begin
                saved_req <= mem_req;
            end
        end
        if (state == st_refill && cbus_resp.okay)
            line_mem[beat] <= fill_word;
    end

    // processor side
    assign mem_resp.addr_ok = state == st_idle;
    assign mem_resp.data_ok = (state == st_idle && mem_req.req && tag_hit) ||
                              (state == st_refill && cbus_resp.okay && offset_hit);
    // miss data comes straight from the bus
    assign mem_resp.rdata   = state == st_idle ? line_mem[req_addr.index].word
                                               : fill_word.word;

    // bus master
    assign cbus_req.valid    = state != st_idle;
    assign cbus_req.is_write = state == st_write_back;
    assign cbus_req.wdata    = line_mem[beat].word;
    assign cbus_req.addr     = {
        (state == st_write_back ? tag : saved_addr.tag),
        {(index_bits + align_bits){1'b0}}
    };

endmodule

`default_nettype wire

/* verilog/burst_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_ram
    import cache_pkg::*;
#(
    parameter int line_words = 16,
    parameter int ram_words  = 1024
) (
    input  logic       clk,
    input  logic       reset,
    input  cbus_req_t  cbus_req,
    output cbus_resp_t cbus_resp
);

    localparam int ram_bits  = $clog2(ram_words);
    localparam int beat_bits = $clog2(line_words);

    typedef logic [ram_bits - 1:0]  ram_addr_t;
    typedef logic [beat_bits - 1:0] beat_t;

    word_t     ram [ram_words];
    logic      busy;
    beat_t     beat;
    ram_addr_t line_base;
    ram_addr_t word_addr;

    // start contents, low half is the word address
    initial begin
        for (int a = 0; a < ram_words; a++)
            ram[a] = {16'hc0de, a[15:0]};
    end

    assign line_base = cbus_req.addr[align_shift() +: ram_bits];
    assign word_addr = line_base + ram_addr_t'(beat);

    function automatic int align_shift();
        return $clog2(bytes_per_word);
    endfunction

    // one idle cycle before each burst, then a beat per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (!busy) begin
            beat <= '0;
            if (cbus_req.valid)
                busy <= 1'b1;
        end else begin
            beat <= beat + 1'b1;
            if (&beat)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && cbus_req.is_write)
            ram[word_addr] <= cbus_req.wdata;
    end

    assign cbus_resp.okay  = busy;
    assign cbus_resp.last  = busy && (&beat);
    assign cbus_resp.rdata = ram[word_addr];

endmodule

`default_nettype wire

/* verilog/line_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_top
    import cache_pkg::*;
#(
    parameter int line_words = 16,
    parameter int ram_words  = 1024
) (
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);

    // cache bus between buffer and backing memory
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    one_line_buffer #(
        .line_words (line_words)
    ) buffer_i (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    burst_ram #(
        .line_words (line_words),
        .ram_words  (ram_words)
    ) ram_i (
        .clk       (clk),
        .reset     (reset),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

endmodule

`default_nettype wire

/* verif/line_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_tb
    import cache_pkg::*;
();

    localparam int line_words     = 16;
    localparam int ram_words      = 1024;
    localparam int timeout_cycles = 500;

    typedef struct packed {
        logic         wr;
        access_size_t size;
        addr_t        addr;
        word_t        wdata;
        logic         check;
    } entry_t;

    logic      clk;
    logic      reset;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    entry_t table_q [$];
    // mirror of the backing memory
    word_t  model_mem [ram_words];
    int     errors;
    int     tests;
    int     seed;
    int     data_ok_seen = 0;
    logic   hung;

    line_buffer_top #(
        .line_words (line_words),
        .ram_words  (ram_words)
    ) line_buffer_top_i (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    always #10 clk = ~clk;

    // counts every data_ok pulse including extra ones
    always @(negedge clk) begin
        if (!reset && mem_resp.data_ok)
            data_ok_seen = data_ok_seen + 1;
    end

    function automatic strobe_t lane_mask(access_size_t size, logic [1:0] offset);
        strobe_t mask;
        for (int i = 0; i < bytes_per_word; i++) begin
            if (size == size_byte)
                mask[i] = i == int'(offset);
            else if (size == size_half)
                mask[i] = i / 2 == int'(offset[1]);
            else
                mask[i] = 1'b1;
        end
        return mask;
    endfunction

    function automatic int word_index(addr_t addr);
        return int'(addr[2 +: $clog2(ram_words)]);
    endfunction

    function automatic void model_write(entry_t e);
        strobe_t mask;
        mask = lane_mask(e.size, e.addr[1:0]);
        for (int i = 0; i < bytes_per_word; i++) begin
            if (mask[i])
                model_mem[word_index(e.addr)][8 * i +: 8] = e.wdata[8 * i +: 8];
        end
    endfunction

    // reads are always compared with the model
    function automatic void add_entry(logic wr, access_size_t size, addr_t addr, word_t wdata);
        table_q.push_back('{wr, size, addr, wdata, !wr});
    endfunction

    function automatic void build_table();
        addr_t       lines [4];
        int unsigned pick;
        access_size_t size;
        word_t       data;
        lines = '{32'h0c0, 32'h340, 32'h780, 32'hf00};
        // cold miss, then the rest of the line hits
        add_entry(1'b0, size_word, 32'h104, '0);
        for (int w = 0; w < line_words; w++)
            add_entry(1'b0, size_word, 32'h100 + 4 * w, '0);
        // write hits, each size at each byte offset
        add_entry(1'b1, size_byte, 32'h104, 32'h111111a1);
        add_entry(1'b1, size_byte, 32'h105, 32'h2222b222);
        add_entry(1'b1, size_byte, 32'h106, 32'h33c33333);
        add_entry(1'b1, size_byte, 32'h107, 32'hd4444444);
        add_entry(1'b1, size_half, 32'h108, 32'h5555e5e5);
        add_entry(1'b1, size_half, 32'h10b, 32'hf6f66666);
        add_entry(1'b1, size_half, 32'h111, 32'h77771717);
        add_entry(1'b1, size_half, 32'h116, 32'h28288888);
        add_entry(1'b1, size_word, 32'h10c, 32'h39393939);
        add_entry(1'b1, size_word, 32'h119, 32'h4a4a4a4a);
        add_entry(1'b1, size_word, 32'h126, 32'h5b5b5b5b);
        add_entry(1'b1, size_word, 32'h12b, 32'h6c6c6c6c);
        for (int w = 0; w < line_words; w++)
            add_entry(1'b0, size_word, 32'h100 + 4 * w, '0);
        // dirty line is evicted, then read back from memory
        add_entry(1'b0, size_word, 32'h804, '0);
        for (int w = 0; w < line_words; w++)
            add_entry(1'b0, size_word, 32'h100 + 4 * w, '0);
        // write misses to a clean and then a dirty victim
        add_entry(1'b1, size_byte, 32'h402, 32'h00ee0000);
        add_entry(1'b0, size_word, 32'h400, '0);
        add_entry(1'b0, size_word, 32'h43c, '0);
        add_entry(1'b1, size_half, 32'h60a, 32'h5a5a0000);
        add_entry(1'b0, size_word, 32'h608, '0);
        add_entry(1'b0, size_word, 32'h60c, '0);
        add_entry(1'b0, size_word, 32'h400, '0);
        add_entry(1'b0, size_word, 32'h60a, '0);
        // random tail over four lines
        for (int n = 0; n < 40; n++) begin
            pick = $unsigned($random(seed));
            data = $random(seed);
            case (pick[9:8])
                2'd0:    size = size_byte;
                2'd1:    size = size_half;
                default: size = size_word;
            endcase
            add_entry(pick[10], size, lines[pick[1:0]] + addr_t'(pick[7:2]), data);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected %h, seen %h", $time, name, expected, actual);
        end
    endtask

    task automatic run_access(input entry_t e, output logic timed_out, output word_t rdata);
        int   waited;
        logic done;
        timed_out = 1'b0;
        done      = 1'b0;
        rdata     = '0;
        @(posedge clk);
        mem_req.req        <= 1'b1;
        mem_req.wr         <= e.wr;
        mem_req.size       <= e.size;
        mem_req.addr       <= e.addr;
        mem_req.wdata.word <= e.wdata;
        waited = 0;
        @(negedge clk);
        while (!mem_resp.addr_ok && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_resp.addr_ok) begin
            $display("request to %h was never accepted within %0d cycles", e.addr, waited);
            timed_out = 1'b1;
        end else begin
            // a hit answers in the same cycle
            if (mem_resp.data_ok) begin
                done  = 1'b1;
                rdata = mem_resp.rdata;
            end
            @(posedge clk);
            mem_req.req <= 1'b0;
            waited = 0;
            while (!done && waited < timeout_cycles) begin
                @(negedge clk);
                waited++;
                if (mem_resp.data_ok) begin
                    done  = 1'b1;
                    rdata = mem_resp.rdata;
                end
            end
            if (!done) begin
                $display("request to %h got no data_ok within %0d cycles", e.addr, waited);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        entry_t e;
        word_t  rdata;
        logic   timed_out;
        int     errors_before;
        clk     = 1'b0;
        reset   <= 1'b1;
        mem_req <= '0;
        errors  = 0;
        tests   = 0;
        hung    = 1'b0;
        seed    = 35112;
        for (int a = 0; a < ram_words; a++)
            model_mem[a] = {16'hc0de, a[15:0]};
        build_table();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("addr_ok after reset", 32'd1, 32'(mem_resp.addr_ok));
        check_value("data_ok after reset", 32'd0, 32'(mem_resp.data_ok));

        foreach (table_q[i]) begin
            if (!hung) begin
                e = table_q[i];
                errors_before = errors;
                run_access(e, timed_out, rdata);
                if (timed_out) begin
                    hung = 1'b1;
                end else begin
                    tests++;
                    if (e.wr)
                        model_write(e);
                    else if (e.check)
                        check_value($sformatf("rdata of entry %0d", i),
                                    model_mem[word_index(e.addr)], rdata);
                    $display("entry %0d: %s size %0d at %h %s", i, e.wr ? "write" : "read",
                             e.size, e.addr, errors == errors_before ? "ok" : "failed");
                end
            end
        end

        // room for a stray late data_ok
        repeat (4) @(posedge clk);
        if (!hung)
            check_value("data_ok count", tests, data_ok_seen);
        $display("%0d errors in %0d tests", errors, tests);
        if (errors == 0 && !hung) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/cache_pkg.sv
verilog/strobe_translator.sv
verilog/one_line_buffer.sv
verilog/burst_ram.sv
verilog/line_buffer_top.sv
verif/line_buffer_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, then judge the log
rm -f sim.log
verilator --binary -j 0 -Wno-fatal --top-module line_buffer_tb -f files.f \
    && ./obj_dir/Vline_buffer_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
